//--- filelist.f
+incdir+include
source/fabricTilePkg.sv
source/regFileBel.sv
source/tileHostPort.sv
source/readCollector.sv
source/regFileTile.sv
tests/regFileTileTb.sv

//--- include/fabricTile_settings.svh
`ifndef FABRIC_TILE_SETTINGS_SVH
`define FABRIC_TILE_SETTINGS_SVH

// Number of register files held by one tile
`define NumBels 4
// Select bits that pick one register file out of the tile
`define BelSelWidth 2

// Each register file has 32 entries of one nibble
`define RegAddrWidth 5
`define RegDataWidth 4

// Bit 0 makes read port A registered and bit 1 makes read port B registered
`define NoConfigBits 2

// Host bus widths
`define WbAddrWidth 16
`define WbDataWidth 8

`endif

//--- runSim.sh
#!/bin/sh
# Builds the tile testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module regFileTileTb -o simRegFileTile

./obj_dir/simRegFileTile > sim.log 2>&1
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- source/fabricTilePkg.sv
`include "fabricTile_settings.svh"

package fabricTilePkg;

  // Address seen as a register access
  // Port A also supplies the write address
  typedef struct packed {
    logic isConfig;
    logic [`BelSelWidth-1:0] bel;
    logic [`RegAddrWidth-1:0] aAdr;
    logic [`RegAddrWidth-1:0] bAdr;
    logic [`WbAddrWidth-2-`BelSelWidth-2*`RegAddrWidth:0] spare;
  } wbRegAddrT;

  // Address seen as a configuration access
  typedef struct packed {
    logic isConfig;
    logic [`BelSelWidth-1:0] bel;
    logic [`WbAddrWidth-2-`BelSelWidth:0] spare;
  } wbCfgAddrT;

  // Both views cover the same 16 bit host address
  typedef union packed {
    wbRegAddrT regView;
    wbCfgAddrT cfgView;
  } wbAddrU;

  // Write strobe shared by every register file in the tile
  typedef struct packed {
    logic en;
    logic [`BelSelWidth-1:0] bel;
    logic [`RegAddrWidth-1:0] wAdr;
    logic [`RegDataWidth-1:0] data;
  } belWriteT;

  // Read addresses broadcast to all register files
  typedef struct packed {
    logic [`RegAddrWidth-1:0] aAdr;
    logic [`RegAddrWidth-1:0] bAdr;
  } belReadT;

  // One cycle request from the host port to the collector
  typedef struct packed {
    logic valid;
    logic isConfig;
    logic [`BelSelWidth-1:0] bel;
  } readReqT;

  // Registered answer with a one cycle done strobe
  typedef struct packed {
    logic done;
    logic [`WbDataWidth-1:0] data;
  } readRespT;

  typedef logic [`NoConfigBits-1:0] belCfgT;

endpackage

//--- source/readCollector.sv
`include "fabricTile_settings.svh"

module readCollector (
  input  logic                     UserCLK,
  input  logic                     rst,
  input  fabricTilePkg::readReqT   req,
  input  logic [`RegDataWidth-1:0] AD [`NumBels],
  input  logic [`RegDataWidth-1:0] BD [`NumBels],
  input  fabricTilePkg::belCfgT    cfg [`NumBels],
  output fabricTilePkg::readRespT  resp
);

  // Data picked from the addressed register file
  logic [`WbDataWidth-1:0] selData;

  // Registered answer
  logic                    doneQ;
  logic [`WbDataWidth-1:0] dataQ;

  // Configuration reads return the bits zero extended
  // Register reads put port B in the high nibble and port A in the low nibble
  always_comb begin
    if (req.isConfig) begin
      selData = {{(`WbDataWidth - `NoConfigBits){1'b0}}, cfg[req.bel]};
    end else begin
      selData = {BD[req.bel], AD[req.bel]};
    end
  end

  // Done is a single cycle pulse that trails the request by one edge
  always_ff @(posedge UserCLK) begin
    if (rst) begin
      doneQ <= 1'b0;
    end else begin
      doneQ <= req.valid;
    end
  end

  // The data register only loads on a request
  always_ff @(posedge UserCLK) begin
    if (req.valid) begin
      dataQ <= selData;
    end
  end

  assign resp.done = doneQ;
  assign resp.data = dataQ;

  // A request is answered on the next edge and the answer lasts a single cycle
  doneFollowsReq: assert property (
    @(posedge UserCLK) disable iff (rst) req.valid |=> resp.done ##1 !resp.done
  );

  // The addressed register file must hand back known data when a request is taken
  selDataKnown: assert property (
    @(posedge UserCLK) disable iff (rst) req.valid |-> !$isunknown(selData)
  );

endmodule

//--- source/regFileBel.sv
`include "fabricTile_settings.svh"

module regFileBel (
  input  logic                     UserCLK,
  input  logic [`BelSelWidth-1:0]  belIndex,
  input  fabricTilePkg::belWriteT  wr,
  input  fabricTilePkg::belReadT   rd,
  input  fabricTilePkg::belCfgT    cfg,
  output logic [`RegDataWidth-1:0] AD,
  output logic [`RegDataWidth-1:0] BD
);

  // 32 entries of one nibble
  logic [`RegDataWidth-1:0] mem [2**`RegAddrWidth];

  // Combinational read data of both ports
  logic [`RegDataWidth-1:0] adComb;
  logic [`RegDataWidth-1:0] bdComb;

  // Output registers that follow the combinational data every cycle
  logic [`RegDataWidth-1:0] adReg;
  logic [`RegDataWidth-1:0] bdReg;

  // The write is shared by the tile, so only the addressed copy takes it
  logic writeHit;

  // Memory contents start at zero and are never touched by reset
  initial begin
    for (int i = 0; i < 2**`RegAddrWidth; i++) begin
      mem[i] = '0;
    end
  end

  assign writeHit = wr.en && (wr.bel == belIndex);

  always_ff @(posedge UserCLK) begin
    if (writeHit) begin
      mem[wr.wAdr] <= wr.data;
    end
  end

  assign adComb = mem[rd.aAdr];
  assign bdComb = mem[rd.bAdr];

  // Both registers sample at every edge whatever the mode
  always_ff @(posedge UserCLK) begin
    adReg <= adComb;
    bdReg <= bdComb;
  end

  // Configuration bit 0 picks port A's register and bit 1 picks port B's
  assign AD = cfg[0] ? adReg : adComb;
  assign BD = cfg[1] ? bdReg : bdComb;

  // The host port must never send a write with an unknown address
  writeAddrKnown: assert property (@(posedge UserCLK) wr.en |-> !$isunknown(wr.wAdr));

endmodule

//--- source/regFileTile.sv
`include "fabricTile_settings.svh"

module regFileTile (
  input  logic                    UserCLK,
  input  logic                    rst,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  fabricTilePkg::wbAddrU   adr,
  input  logic [`WbDataWidth-1:0] datWr,
  output logic                    ack,
  output logic [`WbDataWidth-1:0] datRd
);

  import fabricTilePkg::*;

  // Write strobe and read addresses are shared by all register files
  belWriteT wr;
  belReadT  rd;

  // Per register file configuration bits and read data
  belCfgT                   cfg [`NumBels];
  logic [`RegDataWidth-1:0] AD  [`NumBels];
  logic [`RegDataWidth-1:0] BD  [`NumBels];

  // Handshake between the host port and the collector
  readReqT  readReq;
  readRespT resp;

  tileHostPort uHostPort (
    .UserCLK(UserCLK),
    .rst(rst),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .datWr(datWr),
    .resp(resp),
    .ack(ack),
    .datRd(datRd),
    .wr(wr),
    .rd(rd),
    .cfg(cfg),
    .readReq(readReq)
  );

  // Each copy learns its own index so it can pick its writes out of the shared strobe
  for (genvar g = 0; g < `NumBels; g++) begin : gBel
    regFileBel uBel (
      .UserCLK(UserCLK),
      .belIndex(`BelSelWidth'(g)),
      .wr(wr),
      .rd(rd),
      .cfg(cfg[g]),
      .AD(AD[g]),
      .BD(BD[g])
    );
  end

  readCollector uCollector (
    .UserCLK(UserCLK),
    .rst(rst),
    .req(readReq),
    .AD(AD),
    .BD(BD),
    .cfg(cfg),
    .resp(resp)
  );

endmodule

//--- source/tileHostPort.sv
`include "fabricTile_settings.svh"

module tileHostPort (
  input  logic                     UserCLK,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  fabricTilePkg::wbAddrU    adr,
  input  logic [`WbDataWidth-1:0]  datWr,
  input  fabricTilePkg::readRespT  resp,
  output logic                     ack,
  output logic [`WbDataWidth-1:0]  datRd,
  output fabricTilePkg::belWriteT  wr,
  output fabricTilePkg::belReadT   rd,
  output fabricTilePkg::belCfgT    cfg [`NumBels],
  output fabricTilePkg::readReqT   readReq
);

  // A read stays outstanding from its first edge until the collector answers
  logic busy;

  // High only in the cycle that opens a new access
  logic start;

  // Decoded kinds of a new access
  logic cfgWrite;
  logic regWrite;
  logic readStart;

  // Ack and busy keep one bus cycle from starting a second operation
  assign start = cyc && stb && !ack && !busy;

  // Configuration accesses are decoded through the short view
  assign cfgWrite = start && we && adr.cfgView.isConfig;
  // Register accesses are decoded through the full view
  assign regWrite = start && we && !adr.regView.isConfig;
  assign readStart = start && !we;

  // The memory takes the write at the edge that opens the access
  assign wr.en = regWrite;
  assign wr.bel = adr.regView.bel;
  assign wr.wAdr = adr.regView.aAdr;
  assign wr.data = datWr[`RegDataWidth-1:0];

  // Read addresses come straight from the bus and the master holds them until ack
  assign rd.aAdr = adr.regView.aAdr;
  assign rd.bAdr = adr.regView.bAdr;

  // Configuration bits of every register file
  always_ff @(posedge UserCLK) begin
    if (rst) begin
      cfg <= '{default: '0};
    end else if (cfgWrite) begin
      cfg[adr.cfgView.bel] <= datWr[`NoConfigBits-1:0];
    end
  end

  // A read sends a single request pulse to the collector
  always_ff @(posedge UserCLK) begin
    if (rst) begin
      readReq <= '0;
    end else begin
      readReq.valid <= readStart;
      readReq.isConfig <= adr.cfgView.isConfig;
      readReq.bel <= adr.cfgView.bel;
    end
  end

  // Writes ack one cycle after they open and reads ack one cycle after done
  always_ff @(posedge UserCLK) begin
    if (rst) begin
      ack <= 1'b0;
      busy <= 1'b0;
    end else begin
      ack <= regWrite || cfgWrite || resp.done;
      if (readStart) begin
        busy <= 1'b1;
      end else if (resp.done) begin
        busy <= 1'b0;
      end
    end
  end

  // Read data is latched together with ack
  always_ff @(posedge UserCLK) begin
    if (resp.done) begin
      datRd <= resp.data;
    end
  end

  // The master holds the bus while ack is up
  ackInCycle: assert property (@(posedge UserCLK) disable iff (rst) ack |-> (cyc && stb));

  // Each access gets a single ack
  ackOnePulse: assert property (@(posedge UserCLK) disable iff (rst) ack |=> !ack);

  // The collector sees each read once
  reqOnePulse: assert property (
    @(posedge UserCLK) disable iff (rst) readReq.valid |=> !readReq.valid
  );

endmodule

//--- tests/regFileTileTb.sv
`include "fabricTile_settings.svh"

module regFileTileTb;
  timeunit 1ns;
  timeprecision 100ps;

  import fabricTilePkg::*;

  localparam int resetCycles = 16;
  // Accesses issued by all tests together, used to size the watchdog
  localparam int numAccesses = 364;
  localparam int ackTimeout = 20;

  logic UserCLK;
  logic rst;
  logic cyc;
  logic stb;
  logic we;
  logic ack;
  wbAddrU adr;
  logic [`WbDataWidth-1:0] datWr;
  logic [`WbDataWidth-1:0] datRd;

  // Software copy of every register file and of its configuration bits
  logic [`RegDataWidth-1:0] modelMem [`NumBels][2**`RegAddrWidth];
  belCfgT modelCfg [`NumBels];
  int errorCount = 0;
  int testsFailed = 0;

  regFileTile UUT (.*);

  initial begin
    UserCLK = 1'b0;
    forever #50 UserCLK = ~UserCLK;
  end

  // Each access needs far fewer than ten cycles, so this only fires on a hang
  initial begin
    repeat (numAccesses * 10 + resetCycles) @(posedge UserCLK);
    $display("Watchdog expired before the tests completed");
    $display("Done: errors found");
    $finish;
  end

  task automatic checkEqual(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    if (got !== expected) begin
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  // Register view with isConfig clear and the spare bits zero
  function automatic wbAddrU registerAddress(input int bel, input int aAdr, input int bAdr);
    wbAddrU a;
    a = '0;
    a.regView.bel = `BelSelWidth'(bel);
    a.regView.aAdr = `RegAddrWidth'(aAdr);
    a.regView.bAdr = `RegAddrWidth'(bAdr);
    return a;
  endfunction

  function automatic wbAddrU configAddress(input int bel);
    wbAddrU a;
    a = '0;
    a.cfgView.isConfig = 1'b1;
    a.cfgView.bel = `BelSelWidth'(bel);
    return a;
  endfunction

  // One Wishbone classic access, counting falling edges until ack is seen
  // A write acks right after its opening edge and a read two edges later
  task automatic busCycle(input logic write, input wbAddrU addr, input logic [7:0] wData,
                          output logic [7:0] rData);
    int waited;
    @(negedge UserCLK);
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    datWr = wData;
    @(negedge UserCLK);
    waited = 1;
    while (!ack && waited < ackTimeout) begin
      @(negedge UserCLK);
      waited++;
    end
    if (!ack) begin
      $display("Access to address %h got no ack within %0d cycles", addr, ackTimeout);
      errorCount++;
    end else begin
      checkEqual(32'(waited), write ? 32'd1 : 32'd3, "ack latency");
    end
    rData = datRd;
    // The bus stays up through the edge that samples ack and drops in the next cycle
    @(negedge UserCLK);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wbWrite(input wbAddrU addr, input logic [7:0] data);
    logic [7:0] unused;
    busCycle(1'b1, addr, data, unused);
  endtask

  task automatic wbRead(input wbAddrU addr, output logic [7:0] data);
    busCycle(1'b0, addr, 8'h00, data);
  endtask

  task automatic writeEntry(input int bel, input int entry, input logic [3:0] value);
    wbWrite(registerAddress(bel, entry, 0), {4'h0, value});
    modelMem[bel][entry] = value;
  endtask

  task automatic setConfig(input int bel, input int pattern);
    wbWrite(configAddress(bel), 8'(pattern));
    modelCfg[bel] = `NoConfigBits'(pattern);
  endtask

  // Port B lands in the high nibble and port A in the low nibble
  task automatic pairedRead(input int bel, input int aAdr, input int bAdr);
    logic [7:0] got;
    wbRead(registerAddress(bel, aAdr, bAdr), got);
    checkEqual(32'(got), 32'({modelMem[bel][bAdr], modelMem[bel][aAdr]}),
               $sformatf("bel %0d read a=%0d b=%0d", bel, aAdr, bAdr));
  endtask

  task automatic configReadBack(input int bel);
    logic [7:0] got;
    wbRead(configAddress(bel), got);
    checkEqual(32'(got), 32'(modelCfg[bel]), $sformatf("bel %0d config", bel));
  endtask

  // Steps from a start value until no register file holds it at this entry
  function automatic logic [3:0] freshValue(input int entry, input logic [3:0] start);
    logic [3:0] v;
    logic clash;
    v = start;
    clash = 1'b1;
    while (clash) begin
      clash = 1'b0;
      for (int j = 0; j < `NumBels; j++) begin
        if (modelMem[j][entry] == v) begin
          clash = 1'b1;
        end
      end
      if (clash) begin
        v++;
      end
    end
    return v;
  endfunction

  task automatic reportTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, errorCount - errorsBefore);
      testsFailed++;
    end
  endtask

  task automatic resetState();
    int errorsBefore;
    errorsBefore = errorCount;
    checkEqual(32'(ack), 32'd0, "ack after reset");
    for (int k = 0; k < `NumBels; k++) configReadBack(k);
    // Port A walks the lower half and port B the upper half, so every entry is seen
    for (int k = 0; k < `NumBels; k++) begin
      for (int e = 0; e < 16; e++) pairedRead(k, e, e + 16);
    end
    reportTest("resetState", errorsBefore);
  endtask

  task automatic combinationalAccess();
    int errorsBefore;
    int a;
    int b;
    errorsBefore = errorCount;
    for (int k = 0; k < `NumBels; k++) begin
      for (int r = 0; r < 2; r++) begin
        a = int'($urandom_range(31, 0));
        b = a ^ int'($urandom_range(31, 1));
        writeEntry(k, a, 4'($urandom()));
        pairedRead(k, a, a);
        writeEntry(k, b, 4'($urandom()));
        pairedRead(k, a, b);
      end
    end
    reportTest("combinationalAccess", errorsBefore);
  endtask

  // Registered and combinational outputs must return identical data
  task automatic configPatterns();
    int errorsBefore;
    errorsBefore = errorCount;
    for (int p = 0; p < 4; p++) begin
      for (int k = 0; k < `NumBels; k++) setConfig(k, (p + k) % 4);
      for (int k = 0; k < `NumBels; k++) configReadBack(k);
      for (int k = 0; k < `NumBels; k++) begin
        pairedRead(k, int'($urandom_range(31, 0)), int'($urandom_range(31, 0)));
      end
    end
    reportTest("configPatterns", errorsBefore);
  endtask

  task automatic writeIsolation();
    int errorsBefore;
    int e;
    errorsBefore = errorCount;
    for (int k = 0; k < `NumBels; k++) begin
      e = int'($urandom_range(31, 0));
      // The new value differs from what every copy holds now, so a leaked write shows up
      writeEntry(k, e, freshValue(e, ~modelMem[k][e]));
      for (int j = 0; j < `NumBels; j++) pairedRead(j, e, e);
    end
    reportTest("writeIsolation", errorsBefore);
  endtask

  task automatic randomFill();
    int errorsBefore;
    errorsBefore = errorCount;
    for (int k = 0; k < `NumBels; k++) setConfig(k, int'($urandom_range(3, 0)));
    for (int k = 0; k < `NumBels; k++) begin
      for (int e = 0; e < 2**`RegAddrWidth; e++) writeEntry(k, e, 4'($urandom()));
    end
    for (int n = 0; n < 64; n++) begin
      pairedRead(int'($urandom_range(3, 0)), int'($urandom_range(31, 0)),
                 int'($urandom_range(31, 0)));
    end
    reportTest("randomFill", errorsBefore);
  endtask

  initial begin
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datWr = '0;
    for (int k = 0; k < `NumBels; k++) begin
      modelCfg[k] = '0;
      for (int e = 0; e < 2**`RegAddrWidth; e++) modelMem[k][e] = '0;
    end
    void'($urandom(32'h40e04114));
    repeat (resetCycles) @(posedge UserCLK);
    @(negedge UserCLK);
    rst = 1'b0;
    resetState();
    combinationalAccess();
    configPatterns();
    writeIsolation();
    randomFill();
    $display("Tests run 5, tests failed %0d, errors %0d", testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
